/* tb.f */
+incdir+include
hw/gmii_pkg.sv
hw/avalon_st_pkg.sv
hw/gmii_preamble_detect.sv
hw/gmii_word_packer.sv
hw/avalon_eop_merge.sv
hw/gmii_to_avalon_rx.sv
test/rx_stream_checker.sv
test/gmii_to_avalon_rx_asserts.sv
test/tb_gmii_to_avalon_rx.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_gmii_to_avalon_rx
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_gmii_to_avalon_rx.sv */
// testbench for the GMII to Avalon-ST receive path
// drives framed GMII words from an LFSR, builds the expected beats
// with a reference function and hands them to the stream checker

`timescale 1ns/1ns
`default_nettype none

`include "gmii_avalon_defs.svh"

module tb_gmii_to_avalon_rx;

    import gmii_pkg::*;
    import avalon_st_pkg::*;

    localparam int DRAIN_TIMEOUT = 300; // cycles

    logic        avalon_clk;
    logic        reset;
    gmii_lanes_t gmii_enable;
    gmii_word_t  gmii_data;
    gmii_lanes_t gmii_error;
    avs_data_t   avalon_rx_data;
    logic        avalon_rx_valid;
    logic        avalon_rx_sop;
    logic        avalon_rx_eop;
    avs_empty_t  avalon_rx_empty;
    logic        avalon_rx_error;

    logic [15:0] lfsr_state = 16'd38183;
    logic [7:0]  frame_bytes[$]; // wire order
    bit          frame_errs[$];  // one flag per byte
    int          timeouts = 0;

    gmii_to_avalon_rx i_gmii_to_avalon_rx (
        .avalon_clk     (avalon_clk),
        .reset          (reset),
        .gmii_enable    (gmii_enable),
        .gmii_data      (gmii_data),
        .gmii_error     (gmii_error),
        .avalon_rx_data (avalon_rx_data),
        .avalon_rx_valid(avalon_rx_valid),
        .avalon_rx_sop  (avalon_rx_sop),
        .avalon_rx_eop  (avalon_rx_eop),
        .avalon_rx_empty(avalon_rx_empty),
        .avalon_rx_error(avalon_rx_error)
    );

    rx_stream_checker i_rx_stream_checker (
        .avalon_clk     (avalon_clk),
        .reset          (reset),
        .avalon_rx_data (avalon_rx_data),
        .avalon_rx_valid(avalon_rx_valid),
        .avalon_rx_sop  (avalon_rx_sop),
        .avalon_rx_eop  (avalon_rx_eop),
        .avalon_rx_empty(avalon_rx_empty),
        .avalon_rx_error(avalon_rx_error)
    );

    initial begin
        avalon_clk = 1'b0;
        forever #20 avalon_clk = ~avalon_clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hb400;
        return out;
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        int i;
        v = 0;
        for (i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    // expected beat j of the frame held in frame_bytes
    function automatic avs_beat_s expected_beat(input int j);
        avs_beat_s b;
        int n;
        int k;
        int idx;
        int bytes_in_beat;
        n = frame_bytes.size();
        b.data  = '0;
        b.error = 1'b0;
        for (k = 0; k < 8; k++) begin
            idx = 8*j + k;
            if (idx < n) begin
                b.data[`AVS_DATA_W-1 - 8*k -: 8] = frame_bytes[idx]; // first byte on top
                b.error = b.error | frame_errs[idx];
            end
        end
        bytes_in_beat = (n - 8*j > 8) ? 8 : n - 8*j;
        b.sop   = (j == 0);
        b.eop   = (8*(j+1) >= n);
        b.empty = b.eop ? avs_empty_t'(8 - bytes_in_beat) : '0;
        return b;
    endfunction

    task automatic drive_word(input gmii_lanes_t en, input gmii_word_t d,
                              input gmii_lanes_t er);
        @(posedge avalon_clk);
        gmii_enable <= en;
        gmii_data   <= d;
        gmii_error  <= er;
    endtask

    task automatic idle_words(input int n);
        int i;
        for (i = 0; i < n; i++)
            drive_word(2'b00, gmii_word_t'(rand_bits(16)), 2'b00);
    endtask

    task automatic fill_frame(input int n, input int err_at);
        int i;
        frame_bytes.delete();
        frame_errs.delete();
        for (i = 0; i < n; i++) begin
            frame_bytes.push_back(8'(rand_bits(8)));
            frame_errs.push_back(i == err_at);
        end
    endtask

    // broken_at replaces one preamble word, -1 keeps them all clean
    task automatic send_frame(input int pre_len, input int broken_at,
                              input gmii_word_t sfd, input bit good);
        int n;
        int i;
        int j;
        n = frame_bytes.size();
        if (good) begin
            for (j = 0; 8*j < n; j++)
                i_rx_stream_checker.push_expected(expected_beat(j));
        end
        for (i = 0; i < pre_len; i++)
            drive_word(2'b11, (i == broken_at) ? 16'h5554 : `PREAMBLE_WORD, 2'b00);
        drive_word(2'b11, sfd, 2'b00);
        for (i = 0; i + 1 < n; i += 2)
            drive_word(2'b11, {frame_bytes[i], frame_bytes[i+1]},
                       {frame_errs[i], frame_errs[i+1]});
        if (n % 2 == 1)
            drive_word(2'b10, {frame_bytes[n-1], 8'(rand_bits(8))}, {frame_errs[n-1], 1'b0});
        else
            drive_word(2'b00, gmii_word_t'(rand_bits(16)), 2'b00);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (i_rx_stream_checker.pending_count() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge avalon_clk);
            cycles++;
        end
        if (i_rx_stream_checker.pending_count() > 0) begin
            $display("timeout: %0d expected beats never left the DUT",
                     i_rx_stream_checker.pending_count());
            timeouts++;
        end
    endtask

    initial begin
        int len;
        int k;
        int err_pos;
        int assert_fails;
        gmii_enable = '0;
        gmii_data   = '0;
        gmii_error  = '0;
        reset       = 1'b1;
        repeat (5) @(posedge avalon_clk);
        reset <= 1'b0;
        idle_words(4);

        for (len = 8; len <= 32; len += 8) begin // ends on a beat boundary
            fill_frame(len, -1);
            send_frame(3, -1, `SFD_WORD, 1'b1);
            idle_words(3);
        end
        wait_drain();

        for (len = 1; len <= 17; len++) begin
            fill_frame(len, -1);
            send_frame(3, -1, `SFD_WORD, 1'b1);
            idle_words(2);
        end
        wait_drain();

        // short preamble, broken preamble, wrong delimiter
        fill_frame(12, -1);
        send_frame(2, -1, `SFD_WORD, 1'b0);
        idle_words(4);
        fill_frame(12, -1);
        send_frame(4, 1, `SFD_WORD, 1'b0);
        idle_words(4);
        fill_frame(12, -1);
        send_frame(3, -1, 16'h55d4, 1'b0);
        idle_words(12);
        fill_frame(20, -1);
        send_frame(7, -1, `SFD_WORD, 1'b1); // long preamble is fine
        idle_words(4);
        wait_drain();

        for (k = 0; k < 8; k++) begin
            len     = 9 + int'(rand_bits(5));
            err_pos = int'(rand_bits(8)) % len;
            fill_frame(len, err_pos);
            send_frame(3, -1, `SFD_WORD, 1'b1);
            idle_words(3);
        end
        wait_drain();

        fill_frame(0, -1); // delimiter straight into the end word
        send_frame(3, -1, `SFD_WORD, 1'b1);
        fill_frame(10, -1);
        send_frame(3, -1, `SFD_WORD, 1'b1);
        idle_words(4);
        wait_drain();

        for (k = 0; k < 24; k++) begin
            len = 1 + int'(rand_bits(6));
            fill_frame(len, -1);
            send_frame(3 + int'(rand_bits(2)), -1, `SFD_WORD, 1'b1);
            idle_words(int'(rand_bits(2))); // zero gap gives back-to-back frames
        end
        idle_words(8);
        wait_drain();
        idle_words(10);

        assert_fails = i_gmii_to_avalon_rx.i_gmii_to_avalon_rx_asserts.fail_count;
        $display("beats checked %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 i_rx_stream_checker.beat_total(), i_rx_stream_checker.error_total(),
                 timeouts, assert_fails);
        if (i_rx_stream_checker.error_total() == 0 && timeouts == 0 && assert_fails == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/gmii_to_avalon_rx_asserts.sv */
// Avalon-ST output protocol assertions for the receive path
// sop and eop only with valid, no sop inside an open packet,
// empty stays zero on beats that do not close a packet

`timescale 1ns/1ns
`default_nettype none

module gmii_to_avalon_rx_asserts (
    input  wire logic                  avalon_clk,
    input  wire logic                  reset,
    input  wire logic                  avalon_rx_valid,
    input  wire logic                  avalon_rx_sop,
    input  wire logic                  avalon_rx_eop,
    input  avalon_st_pkg::avs_empty_t  avalon_rx_empty
);

    int   fail_count = 0;
    logic in_packet; // sop seen, eop not yet

    always_ff @(posedge avalon_clk or posedge reset) begin
        if (reset)
            in_packet <= 1'b0;
        else if (avalon_rx_valid && avalon_rx_eop)
            in_packet <= 1'b0;
        else if (avalon_rx_valid && avalon_rx_sop)
            in_packet <= 1'b1;
    end

    sop_eop_with_valid: assert property (@(posedge avalon_clk) disable iff (reset)
        (avalon_rx_sop || avalon_rx_eop) |-> avalon_rx_valid)
        else begin
            $error("sop or eop raised without valid");
            fail_count = fail_count + 1;
        end

    no_sop_in_packet: assert property (@(posedge avalon_clk) disable iff (reset)
        (avalon_rx_valid && avalon_rx_sop) |-> !in_packet)
        else begin
            $error("sop inside an open packet");
            fail_count = fail_count + 1;
        end

    empty_only_on_eop: assert property (@(posedge avalon_clk) disable iff (reset)
        (avalon_rx_valid && !avalon_rx_eop) |-> (avalon_rx_empty == '0))
        else begin
            $error("nonzero empty on a beat without eop");
            fail_count = fail_count + 1;
        end

endmodule

bind gmii_to_avalon_rx gmii_to_avalon_rx_asserts i_gmii_to_avalon_rx_asserts (
    .avalon_clk     (avalon_clk),
    .reset          (reset),
    .avalon_rx_valid(avalon_rx_valid),
    .avalon_rx_sop  (avalon_rx_sop),
    .avalon_rx_eop  (avalon_rx_eop),
    .avalon_rx_empty(avalon_rx_empty)
);

`default_nettype wire

/* test/rx_stream_checker.sv */
// Avalon-ST receive stream checker
// compares every valid output beat with the head of a queue of
// expected beats and keeps a count of beats and mismatches

`timescale 1ns/1ns
`default_nettype none

module rx_stream_checker (
    input  wire logic                  avalon_clk,
    input  wire logic                  reset,
    input  avalon_st_pkg::avs_data_t   avalon_rx_data,
    input  wire logic                  avalon_rx_valid,
    input  wire logic                  avalon_rx_sop,
    input  wire logic                  avalon_rx_eop,
    input  avalon_st_pkg::avs_empty_t  avalon_rx_empty,
    input  wire logic                  avalon_rx_error
);

    import avalon_st_pkg::*;

    avs_beat_s expect_q[$];
    avs_beat_s exp_b;
    int        beats  = 0;
    int        errors = 0;

    task automatic push_expected(input avs_beat_s b);
        expect_q.push_back(b);
    endtask

    function automatic int pending_count();
        return expect_q.size();
    endfunction

    function automatic int beat_total();
        return beats;
    endfunction

    function automatic int error_total();
        return errors;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %0h expected %0h on beat %0d", name, got, exp, beats);
            errors++;
        end
    endtask

    // outputs are registered, so the values before the edge are stable
    always @(posedge avalon_clk) begin
        if (!reset && avalon_rx_valid) begin
            beats++;
            if (expect_q.size() == 0) begin
                $display("output beat with data %0h arrived while nothing was expected",
                         avalon_rx_data);
                errors++;
            end else begin
                exp_b = expect_q.pop_front();
                check_field("avalon_rx_data", avalon_rx_data, exp_b.data);
                check_field("avalon_rx_sop", 64'(avalon_rx_sop), 64'(exp_b.sop));
                check_field("avalon_rx_eop", 64'(avalon_rx_eop), 64'(exp_b.eop));
                check_field("avalon_rx_empty", 64'(avalon_rx_empty), 64'(exp_b.empty));
                check_field("avalon_rx_error", 64'(avalon_rx_error), 64'(exp_b.error));
            end
        end
    end

endmodule

`default_nettype wire

/* hw/gmii_to_avalon_rx.sv */
// GMII to Avalon-ST receive path, top level
// preamble detector, word packer and eop merge stage in a chain
// one clock domain, no back-pressure on the output stream

`timescale 1ns/1ns
`default_nettype none

module gmii_to_avalon_rx (
    input  wire logic                  avalon_clk,
    input  wire logic                  reset,
    input  gmii_pkg::gmii_lanes_t      gmii_enable,
    input  gmii_pkg::gmii_word_t       gmii_data,
    input  gmii_pkg::gmii_lanes_t      gmii_error,
    output avalon_st_pkg::avs_data_t   avalon_rx_data,
    output logic                       avalon_rx_valid,
    output logic                       avalon_rx_sop,
    output logic                       avalon_rx_eop,
    output avalon_st_pkg::avs_empty_t  avalon_rx_empty,
    output logic                       avalon_rx_error
);

    import gmii_pkg::*;
    import avalon_st_pkg::*;

    gmii_word_s word;
    logic       word_valid;
    avs_beat_s  beat;
    logic       beat_valid;
    logic       end_marker_valid;

    gmii_preamble_detect i_gmii_preamble_detect (
        .avalon_clk (avalon_clk),
        .reset      (reset),
        .gmii_enable(gmii_enable),
        .gmii_data  (gmii_data),
        .gmii_error (gmii_error),
        .word       (word),
        .word_valid (word_valid)
    );

    gmii_word_packer i_gmii_word_packer (
        .avalon_clk      (avalon_clk),
        .reset           (reset),
        .word            (word),
        .word_valid      (word_valid),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .end_marker_valid(end_marker_valid)
    );

    avalon_eop_merge i_avalon_eop_merge (
        .avalon_clk      (avalon_clk),
        .reset           (reset),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .end_marker_valid(end_marker_valid),
        .avalon_rx_data  (avalon_rx_data),
        .avalon_rx_valid (avalon_rx_valid),
        .avalon_rx_sop   (avalon_rx_sop),
        .avalon_rx_eop   (avalon_rx_eop),
        .avalon_rx_empty (avalon_rx_empty),
        .avalon_rx_error (avalon_rx_error)
    );

endmodule

`default_nettype wire

/* hw/avalon_eop_merge.sv */
// Avalon-ST end-of-packet merge stage
// holds each beat without eop until the next beat or end marker
// shows up, so a frame that ends on a beat boundary can flag eop
// on its last full beat; outputs are registered

`timescale 1ns/1ns
`default_nettype none

module avalon_eop_merge (
    input  wire logic                  avalon_clk,
    input  wire logic                  reset,
    input  avalon_st_pkg::avs_beat_s   beat,
    input  wire logic                  beat_valid,
    input  wire logic                  end_marker_valid,
    output avalon_st_pkg::avs_data_t   avalon_rx_data,
    output logic                       avalon_rx_valid,
    output logic                       avalon_rx_sop,
    output logic                       avalon_rx_eop,
    output avalon_st_pkg::avs_empty_t  avalon_rx_empty,
    output logic                       avalon_rx_error
);

    import avalon_st_pkg::*;

    avs_beat_s  hold_q;
    logic       held_q;
    logic       emit_held;
    logic       emit_direct;
    logic       load_hold;

    logic       out_valid_q;
    logic       out_sop_q;
    logic       out_eop_q;
    avs_data_t  out_data_q;
    avs_empty_t out_empty_q;
    logic       out_error_q;

    // a held eop beat drains on its own, others wait for the next event
    assign emit_held   = held_q && (hold_q.eop || beat_valid || end_marker_valid);
    assign emit_direct = !held_q && beat_valid && beat.eop;
    assign load_hold   = beat_valid && (held_q || !beat.eop);

    always_ff @(posedge avalon_clk or posedge reset) begin
        if (reset) begin
            held_q      <= 1'b0;
            out_valid_q <= 1'b0;
            out_sop_q   <= 1'b0;
            out_eop_q   <= 1'b0;
        end else begin
            if (load_hold)
                held_q <= 1'b1;
            else if (emit_held)
                held_q <= 1'b0;
            out_valid_q <= emit_held || emit_direct;
            out_sop_q   <= emit_held ? hold_q.sop : (emit_direct && beat.sop);
            out_eop_q   <= emit_held ? (hold_q.eop || end_marker_valid) : emit_direct;
        end
    end

    always_ff @(posedge avalon_clk) begin
        if (load_hold)
            hold_q <= beat;
        if (emit_held) begin
            out_data_q  <= hold_q.data;
            out_empty_q <= hold_q.empty;
            out_error_q <= hold_q.error;
        end else if (emit_direct) begin
            out_data_q  <= beat.data;
            out_empty_q <= beat.empty;
            out_error_q <= beat.error;
        end
    end

    assign avalon_rx_data  = out_data_q;
    assign avalon_rx_valid = out_valid_q;
    assign avalon_rx_sop   = out_sop_q;
    assign avalon_rx_eop   = out_eop_q;
    assign avalon_rx_empty = out_empty_q;
    assign avalon_rx_error = out_error_q;

endmodule

`default_nettype wire

/* hw/gmii_word_packer.sv */
// GMII word to Avalon-ST beat packer
// places four 16 bit words into a 64 bit beat, first word in
// bits 63:48, and works out sop, eop, empty and error per beat
// a frame ending on a beat boundary with an empty last word
// gives an end marker strobe instead of a beat

`timescale 1ns/1ns
`default_nettype none

`include "gmii_avalon_defs.svh"

module gmii_word_packer (
    input  wire logic                  avalon_clk,
    input  wire logic                  reset,
    input  gmii_pkg::gmii_word_s       word,
    input  wire logic                  word_valid,
    output avalon_st_pkg::avs_beat_s   beat,
    output logic                       beat_valid,
    output logic                       end_marker_valid
);

    import gmii_pkg::*;
    import avalon_st_pkg::*;

    localparam int SLOTS = `AVS_DATA_W / `GMII_WORD_W;

    logic [1:0]  cnt_q;         // next free slot
    logic        sop_pending_q;
    logic        err_acc_q;
    avs_data_t   acc_q;
    avs_beat_s   beat_q;
    logic        beat_valid_q;
    avs_marker_s marker_q;

    gmii_word_t  slot_data;
    logic [1:0]  slot_bytes;
    logic [3:0]  beat_bytes;
    avs_data_t   next_acc;
    logic        err_now;
    logic        full;
    logic        emit_beat;
    logic        emit_marker;

    // unused low byte is forced to zero
    always_comb begin
        case (word.lanes)
            2'b11: begin
                slot_data  = word.data;
                slot_bytes = 2'd2;
            end
            2'b10: begin
                slot_data  = {word.data[15:8], 8'h00};
                slot_bytes = 2'd1;
            end
            default: begin
                slot_data  = '0;
                slot_bytes = 2'd0;
            end
        endcase
    end

    // slot 0 starts from zero so the tail of a short beat stays clear
    always_comb begin
        if (cnt_q == 2'd0)
            next_acc = '0;
        else
            next_acc = acc_q;
        next_acc[`AVS_DATA_W-1 - cnt_q*`GMII_WORD_W -: `GMII_WORD_W] = slot_data;
    end

    assign full        = (cnt_q == 2'(SLOTS - 1));
    assign beat_bytes  = {1'b0, cnt_q, 1'b0} + {2'b00, slot_bytes};
    assign err_now     = err_acc_q | word.err;
    assign emit_marker = word_valid && word.last && (cnt_q == 2'd0) &&
                         (slot_bytes == 2'd0);
    assign emit_beat   = word_valid && (full || word.last) && !emit_marker;

    always_ff @(posedge avalon_clk or posedge reset) begin
        if (reset) begin
            cnt_q              <= '0;
            sop_pending_q      <= 1'b1;
            err_acc_q          <= 1'b0;
            beat_valid_q       <= 1'b0;
            marker_q.frame_end <= 1'b0;
        end else begin
            beat_valid_q       <= emit_beat;
            marker_q.frame_end <= emit_marker;
            if (word_valid) begin
                if (word.last || full) begin
                    cnt_q     <= '0;
                    err_acc_q <= 1'b0;
                end else begin
                    cnt_q     <= cnt_q + 1'b1;
                    err_acc_q <= err_now;
                end
                if (emit_beat || emit_marker)
                    sop_pending_q <= word.last; // next frame starts fresh
            end
        end
    end

    always_ff @(posedge avalon_clk) begin
        if (word_valid)
            acc_q <= next_acc;
        if (emit_beat) begin
            beat_q.data  <= next_acc;
            beat_q.sop   <= sop_pending_q;
            beat_q.eop   <= word.last;
            beat_q.empty <= avs_empty_t'(4'd8 - beat_bytes); // 8 bytes wraps to 0
            beat_q.error <= err_now;
        end
    end

    assign beat             = beat_q;
    assign beat_valid       = beat_valid_q;
    assign end_marker_valid = marker_q.frame_end;

endmodule

`default_nettype wire

/* hw/gmii_preamble_detect.sv */
// GMII preamble and delimiter detector
// waits for at least three 5555 words followed by 55d5, then
// forwards each word of the frame as a strobed word struct
// frame ends on enable 10 (one byte) or enable 00 (no bytes)

`timescale 1ns/1ns
`default_nettype none

`include "gmii_avalon_defs.svh"

module gmii_preamble_detect (
    input  wire logic               avalon_clk,
    input  wire logic               reset,
    input  gmii_pkg::gmii_lanes_t   gmii_enable,
    input  gmii_pkg::gmii_word_t    gmii_data,
    input  gmii_pkg::gmii_lanes_t   gmii_error,
    output gmii_pkg::gmii_word_s    word,
    output logic                    word_valid
);

    import gmii_pkg::*;

    localparam int CNT_W = $clog2(`PREAMBLE_MIN + 1);

    detect_state_e state_q;
    logic [CNT_W-1:0] pre_cnt_q;
    gmii_word_s    word_q;
    logic          word_valid_q;
    logic          is_preamble;
    logic          is_sfd;
    logic          pre_done;
    gmii_lanes_t   lanes_in;

    // clean preamble word, both lanes and no error
    assign is_preamble = (gmii_enable == 2'b11) && (gmii_error == 2'b00) &&
                         (gmii_data == `PREAMBLE_WORD);
    assign is_sfd      = (gmii_enable == 2'b11) && (gmii_data == `SFD_WORD);
    assign pre_done    = (pre_cnt_q == CNT_W'(`PREAMBLE_MIN));

    // enable 01 is not a legal ending, treat it as no bytes
    assign lanes_in = (gmii_enable == 2'b01) ? 2'b00 : gmii_enable;

    always_ff @(posedge avalon_clk or posedge reset) begin
        if (reset) begin
            state_q      <= DET_IDLE;
            pre_cnt_q    <= '0;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= 1'b0;
            case (state_q)
                DET_IDLE: begin
                    if (is_preamble) begin
                        state_q   <= DET_PREAMBLE;
                        pre_cnt_q <= CNT_W'(1);
                    end
                end
                DET_PREAMBLE: begin
                    if (is_preamble) begin
                        if (!pre_done)
                            pre_cnt_q <= pre_cnt_q + 1'b1; // saturates at the minimum
                    end else if (is_sfd && pre_done) begin
                        state_q <= DET_FRAME;
                    end else begin
                        state_q   <= DET_IDLE;
                        pre_cnt_q <= '0;
                    end
                end
                DET_FRAME: begin
                    word_valid_q <= 1'b1;
                    if (gmii_enable != 2'b11) begin
                        state_q   <= DET_IDLE; // this word closes the frame
                        pre_cnt_q <= '0;
                    end
                end
                default: begin
                    state_q   <= DET_IDLE;
                    pre_cnt_q <= '0;
                end
            endcase
        end
    end

    // word payload is loaded every cycle, the strobe says when it counts
    always_ff @(posedge avalon_clk) begin
        word_q.data  <= gmii_data;
        word_q.lanes <= lanes_in;
        word_q.err   <= |gmii_error;
        word_q.last  <= (gmii_enable != 2'b11);
    end

    assign word       = word_q;
    assign word_valid = word_valid_q;

endmodule

`default_nettype wire

/* hw/avalon_st_pkg.sv */
// Avalon-ST side types
// data and empty vectors, the 70 bit beat passed between the
// packer and the merge stage, and the bare end-of-frame marker
// raised when a frame closes exactly on a beat boundary

`default_nettype none

`include "gmii_avalon_defs.svh"

package avalon_st_pkg;

    typedef logic [`AVS_DATA_W-1:0]  avs_data_t;
    typedef logic [`AVS_EMPTY_W-1:0] avs_empty_t;

    typedef struct packed {
        avs_data_t  data;  // first byte in bits 63:56
        logic       sop;
        logic       eop;
        avs_empty_t empty; // unused bytes at the low end
        logic       error;
    } avs_beat_s;

    // frame ended but its last full beat is already gone
    typedef struct packed {
        logic frame_end;
    } avs_marker_s;

endpackage

`default_nettype wire

/* hw/gmii_pkg.sv */
// GMII side types
// word and lane vectors, the word struct handed to the packer
// and the state encoding of the preamble detector

`default_nettype none

`include "gmii_avalon_defs.svh"

package gmii_pkg;

    typedef logic [`GMII_WORD_W-1:0]   gmii_word_t;
    typedef logic [`GMII_WORD_W/8-1:0] gmii_lanes_t; // one bit per byte

    typedef struct packed {
        gmii_word_t  data;
        gmii_lanes_t lanes; // byte enables, bit 1 is the high byte
        logic        err;   // any byte of this word had gmii_error
        logic        last;  // word closes the frame
    } gmii_word_s;

    typedef enum logic [1:0] {
        DET_IDLE,
        DET_PREAMBLE,
        DET_FRAME
    } detect_state_e;

endpackage

`default_nettype wire

/* include/gmii_avalon_defs.svh */
// GMII to Avalon-ST receive path constants
// widths of the GMII word and of the Avalon-ST beat, plus the
// preamble and start-of-frame delimiter patterns seen on the wire

`ifndef GMII_AVALON_DEFS_SVH
`define GMII_AVALON_DEFS_SVH

// one GMII word carries two bytes, bits 15:8 first on the wire
`define GMII_WORD_W 16

// avalon-st beat width and empty count width
`define AVS_DATA_W  64
`define AVS_EMPTY_W 3

// preamble word and delimiter word
`define PREAMBLE_WORD 16'h5555
`define SFD_WORD      16'h55d5

// preamble words needed in a row before the delimiter is accepted
`define PREAMBLE_MIN 3

`endif
